// File: include/ps2_macros.svh
`ifndef PS2_MACROS_SVH
`define PS2_MACROS_SVH

// system clocks without a filtered clock edge that end a frame.
`define PS2_QUIET_CYCLES 5120

// integrator counts where the filtered clock level falls and rises.
`define PS2_INT_LOW  4
`define PS2_INT_HIGH 11

// number of buffered events as a power of two.
`define PS2_FIFO_DEPTH 16

// word addresses taken from adr[3:2].
`define PS2_ADDR_DATA   2'd0
`define PS2_ADDR_STATUS 2'd1
`define PS2_ADDR_CTRL   2'd2

`endif

// File: design/ps2_pkg.sv
`default_nettype none

package ps2_pkg;

  // one received frame.
  typedef struct packed {
    logic       port;
    logic       parity_err;
    logic [7:0] code;
  } ps2_event_t;

  // wishbone classic request from master to slave.
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [3:0]  adr;
    logic [31:0] dat;
  } wb_req_t;

  // wishbone classic response from slave to master.
  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  typedef enum logic {
    WB_IDLE,
    WB_ACK
  } wb_state_e;

endpackage

`default_nettype wire

// File: design/ps2_receiver.sv
`timescale 1ns/1ps
`include "ps2_macros.svh"
`default_nettype none

module ps2_receiver #(
  parameter int PORT_ID      = 0,
  parameter int QUIET_CYCLES = `PS2_QUIET_CYCLES
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                ps2_clk,
  input  logic                ps2_data,
  input  logic                enable,
  output ps2_pkg::ps2_event_t ev,
  output logic                ev_valid,
  input  logic                ev_ack,
  output logic                frame_err,
  output logic                overrun
);
  import ps2_pkg::*;

  localparam int TW = $clog2(QUIET_CYCLES + 1);

  logic [1:0]    clk_sync;
  logic [1:0]    data_sync;
  logic [3:0]    integ;
  logic          lvl;
  logic          lvl_prv;
  logic          fall;
  logic          edge_seen;
  logic [TW-1:0] timer;
  logic          quiet_hit;
  logic [3:0]    bitcnt;
  logic [10:0]   shreg;
  logic          shape_ok;
  logic          frame_ok;
  logic          bad_frame;
  logic          load;

  always_ff @(posedge clk) begin
    if (reset) begin
      clk_sync  <= 2'b11;
      data_sync <= 2'b11;
    end else begin
      clk_sync  <= {clk_sync[0], ps2_clk};
      data_sync <= {data_sync[0], ps2_data};
    end
  end

  // a glitch only moves the saturating integrator a few steps.
  always_ff @(posedge clk) begin
    if (reset) begin
      integ <= 4'hf;
    end else if (clk_sync[1] && integ != 4'hf) begin
      integ <= integ + 4'd1;
    end else if (!clk_sync[1] && integ != 4'h0) begin
      integ <= integ - 4'd1;
    end
  end

  // hysteresis between the two thresholds.
  always_ff @(posedge clk) begin
    if (reset) begin
      lvl     <= 1'b1;
      lvl_prv <= 1'b1;
    end else begin
      lvl_prv <= lvl;
      if (integ == 4'(`PS2_INT_LOW)) begin
        lvl <= 1'b0;
      end else if (integ == 4'(`PS2_INT_HIGH)) begin
        lvl <= 1'b1;
      end
    end
  end

  assign fall      = lvl_prv & ~lvl;
  assign edge_seen = lvl_prv ^ lvl;

  // holds at the limit so a long idle reports only once.
  always_ff @(posedge clk) begin
    if (reset || edge_seen) begin
      timer <= '0;
    end else if (timer != TW'(QUIET_CYCLES)) begin
      timer <= timer + 1'b1;
    end
  end

  assign quiet_hit = !edge_seen && (timer == TW'(QUIET_CYCLES - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      bitcnt <= 4'd0;
    end else if (fall) begin
      if (bitcnt != 4'hf) begin
        bitcnt <= bitcnt + 4'd1;
      end
    end else if (quiet_hit) begin
      bitcnt <= 4'd0;
    end
  end

  // the lsb arrives first so after 11 bits the start bit sits in bit 0.
  always_ff @(posedge clk) begin
    if (fall) begin
      shreg <= {data_sync[1], shreg[10:1]};
    end
  end

  assign shape_ok  = (bitcnt == 4'd11) && !shreg[0] && shreg[10];
  assign frame_ok  = quiet_hit && lvl && shape_ok;
  assign bad_frame = quiet_hit && (!lvl || (bitcnt != 4'd0 && !shape_ok));
  assign load      = frame_ok && enable;

  always_ff @(posedge clk) begin
    if (reset) begin
      ev_valid  <= 1'b0;
      frame_err <= 1'b0;
      overrun   <= 1'b0;
    end else begin
      frame_err <= bad_frame;
      // an unacked event is replaced by the newer one.
      overrun   <= load && ev_valid && !ev_ack;
      if (load) begin
        ev_valid <= 1'b1;
      end else if (ev_ack) begin
        ev_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      ev.port       <= 1'(PORT_ID);
      ev.parity_err <= ~^shreg[9:1];
      ev.code       <= shreg[8:1];
    end
  end

endmodule

`default_nettype wire

// File: design/ps2_event_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_event_arbiter (
  input  logic                      clk,
  input  logic                      reset,
  input  ps2_pkg::ps2_event_t [1:0] req_ev,
  input  logic [1:0]                req_valid,
  output logic [1:0]                req_ack,
  input  logic                      fifo_full,
  output logic                      wr_en,
  output ps2_pkg::ps2_event_t       wr_data
);
  import ps2_pkg::*;

  logic last_grant;

  always_comb begin
    req_ack = 2'b00;
    if (!fifo_full) begin
      if (req_valid == 2'b11) begin
        // with both waiting the port not served last goes first.
        if (last_grant) begin
          req_ack[0] = 1'b1;
        end else begin
          req_ack[1] = 1'b1;
        end
      end else if (req_valid[0]) begin
        req_ack[0] = 1'b1;
      end else if (req_valid[1]) begin
        req_ack[1] = 1'b1;
      end
    end
  end

  assign wr_en   = |req_ack;
  assign wr_data = req_ack[1] ? req_ev[1] : req_ev[0];

  always_ff @(posedge clk) begin
    if (reset) begin
      last_grant <= 1'b1;
    end else if (wr_en) begin
      last_grant <= req_ack[1];
    end
  end

endmodule

`default_nettype wire

// File: design/ps2_event_fifo.sv
`timescale 1ns/1ps
`include "ps2_macros.svh"
`default_nettype none

module ps2_event_fifo (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               wr_en,
  input  ps2_pkg::ps2_event_t                wr_data,
  input  logic                               rd_en,
  output ps2_pkg::ps2_event_t                rd_data,
  output logic [$clog2(`PS2_FIFO_DEPTH):0]   count,
  output logic                               empty,
  output logic                               full
);
  import ps2_pkg::*;

  localparam int DEPTH = `PS2_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);

  ps2_event_t    mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic          do_wr;
  logic          do_rd;

  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // pointers wrap on their own since depth is a power of two.
      if (do_wr && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !do_wr) begin
        count <= count - 1'b1;
      end
    end
  end

  assign rd_data = mem[rd_ptr];
  assign empty   = (count == '0);
  assign full    = (count == (AW + 1)'(DEPTH));

endmodule

`default_nettype wire

// File: design/ps2_wb_regs.sv
`timescale 1ns/1ps
`include "ps2_macros.svh"
`default_nettype none

module ps2_wb_regs (
  input  logic                             clk,
  input  logic                             reset,
  input  ps2_pkg::wb_req_t                 wb_req,
  output ps2_pkg::wb_rsp_t                 wb_rsp,
  output logic                             rd_en,
  input  ps2_pkg::ps2_event_t              rd_data,
  input  logic [$clog2(`PS2_FIFO_DEPTH):0] count,
  input  logic                             empty,
  input  logic [1:0]                       frame_err,
  input  logic [1:0]                       overrun,
  output logic [1:0]                       port_en,
  output logic                             irq
);
  import ps2_pkg::*;

  localparam int CW = $clog2(`PS2_FIFO_DEPTH) + 1;

  wb_state_e   state;
  logic        we_q;
  logic [1:0]  addr_q;
  logic [31:0] wdat_q;
  logic        wr_status;
  logic        wr_ctrl;
  logic        irq_en;
  logic [1:0]  fe_sticky;
  logic [1:0]  ov_sticky;
  logic [31:0] rdata;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= WB_IDLE;
    end else begin
      case (state)
        WB_IDLE: if (wb_req.cyc && wb_req.stb) state <= WB_ACK;
        default: state <= WB_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == WB_IDLE) begin
      we_q   <= wb_req.we;
      addr_q <= wb_req.adr[3:2];
      wdat_q <= wb_req.dat;
    end
  end

  // register side effects all happen in the ack cycle.
  assign wr_status = (state == WB_ACK) && we_q && (addr_q == `PS2_ADDR_STATUS);
  assign wr_ctrl   = (state == WB_ACK) && we_q && (addr_q == `PS2_ADDR_CTRL);
  assign rd_en     = (state == WB_ACK) && !we_q && (addr_q == `PS2_ADDR_DATA) && !empty;

  always_ff @(posedge clk) begin
    if (reset) begin
      fe_sticky <= 2'b00;
      ov_sticky <= 2'b00;
      port_en   <= 2'b11;
      irq_en    <= 1'b0;
      irq       <= 1'b0;
    end else begin
      // a new error in the clearing cycle still sticks.
      fe_sticky <= (fe_sticky & ~(wr_status ? wdat_q[17:16] : 2'b00)) | frame_err;
      ov_sticky <= (ov_sticky & ~(wr_status ? wdat_q[19:18] : 2'b00)) | overrun;
      if (wr_ctrl) begin
        port_en <= wdat_q[1:0];
        irq_en  <= wdat_q[4];
      end
      irq <= irq_en && !empty;
    end
  end

  always_comb begin
    rdata = 32'h0;
    case (addr_q)
      `PS2_ADDR_DATA: begin
        rdata[7:0] = rd_data.code;
        rdata[8]   = rd_data.port;
        rdata[9]   = rd_data.parity_err;
        rdata[31]  = !empty;
      end
      `PS2_ADDR_STATUS: begin
        rdata[CW-1:0] = count;
        rdata[17:16]  = fe_sticky;
        rdata[19:18]  = ov_sticky;
      end
      `PS2_ADDR_CTRL: begin
        rdata[1:0] = port_en;
        rdata[4]   = irq_en;
      end
      default: rdata = 32'h0;
    endcase
  end

  assign wb_rsp.ack = (state == WB_ACK);
  assign wb_rsp.dat = rdata;

endmodule

`default_nettype wire

// File: design/ps2_subsystem.sv
`timescale 1ns/1ps
`include "ps2_macros.svh"
`default_nettype none

module ps2_subsystem #(
  parameter int QUIET_CYCLES = `PS2_QUIET_CYCLES
) (
  input  logic             clk,
  input  logic             reset,
  input  logic [1:0]       ps2_clk,
  input  logic [1:0]       ps2_data,
  input  ps2_pkg::wb_req_t wb_req,
  output ps2_pkg::wb_rsp_t wb_rsp,
  output logic             irq
);
  import ps2_pkg::*;

  ps2_event_t [1:0]                   ev;
  logic [1:0]                         ev_valid;
  logic [1:0]                         ev_ack;
  logic [1:0]                         frame_err;
  logic [1:0]                         overrun;
  logic [1:0]                         port_en;
  logic                               wr_en;
  ps2_event_t                         wr_data;
  logic                               rd_en;
  ps2_event_t                         rd_data;
  logic [$clog2(`PS2_FIFO_DEPTH):0]   count;
  logic                               empty;
  logic                               full;

  // port 0 is the keyboard.
  ps2_receiver #(.PORT_ID(0), .QUIET_CYCLES(QUIET_CYCLES)) ps2_receiver_0_i (
    .clk(clk), .reset(reset),
    .ps2_clk(ps2_clk[0]), .ps2_data(ps2_data[0]), .enable(port_en[0]),
    .ev(ev[0]), .ev_valid(ev_valid[0]), .ev_ack(ev_ack[0]),
    .frame_err(frame_err[0]), .overrun(overrun[0])
  );

  // port 1 is the mouse.
  ps2_receiver #(.PORT_ID(1), .QUIET_CYCLES(QUIET_CYCLES)) ps2_receiver_1_i (
    .clk(clk), .reset(reset),
    .ps2_clk(ps2_clk[1]), .ps2_data(ps2_data[1]), .enable(port_en[1]),
    .ev(ev[1]), .ev_valid(ev_valid[1]), .ev_ack(ev_ack[1]),
    .frame_err(frame_err[1]), .overrun(overrun[1])
  );

  ps2_event_arbiter ps2_event_arbiter_i (
    .clk(clk), .reset(reset),
    .req_ev(ev), .req_valid(ev_valid), .req_ack(ev_ack),
    .fifo_full(full), .wr_en(wr_en), .wr_data(wr_data)
  );

  ps2_event_fifo ps2_event_fifo_i (
    .clk(clk), .reset(reset),
    .wr_en(wr_en), .wr_data(wr_data),
    .rd_en(rd_en), .rd_data(rd_data),
    .count(count), .empty(empty), .full(full)
  );

  ps2_wb_regs ps2_wb_regs_i (
    .clk(clk), .reset(reset),
    .wb_req(wb_req), .wb_rsp(wb_rsp),
    .rd_en(rd_en), .rd_data(rd_data), .count(count), .empty(empty),
    .frame_err(frame_err), .overrun(overrun),
    .port_en(port_en), .irq(irq)
  );

endmodule

`default_nettype wire

// File: verif/ps2_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_assertions (
  input logic             clk,
  input logic             reset,
  input ps2_pkg::wb_rsp_t wb_rsp,
  input logic             wr_en,
  input logic             full,
  input logic [1:0]       req_ack
);

  // the slave goes back to idle right after each ack.
  ack_single: assert property (@(posedge clk) disable iff (reset)
    wb_rsp.ack |=> !wb_rsp.ack)
    else $error("wishbone ack high for two cycles");

  fifo_no_overflow: assert property (@(posedge clk) disable iff (reset)
    wr_en |-> !full)
    else $error("fifo written while full");

  // at most one receiver is served per cycle.
  grant_onehot: assert property (@(posedge clk) disable iff (reset)
    !(&req_ack))
    else $error("both receivers granted in one cycle");

endmodule

`default_nettype wire

// File: verif/ps2_tb.sv
`timescale 1ns/1ps
`include "ps2_macros.svh"
`default_nettype none

module ps2_tb;
  import ps2_pkg::*;

  localparam int QUIET    = 256;
  localparam int HALF_BIT = 40;
  localparam int DEPTH    = `PS2_FIFO_DEPTH;
  localparam logic [31:0] CNT_MASK = 32'h1f;
  localparam logic [31:0] VALID    = 32'h8000_0000;

  typedef enum logic [1:0] {K_GOOD, K_PARITY, K_STOP, K_CUT} kind_e;

  typedef struct packed {
    logic       port;
    logic [7:0] code;
    logic       corrupt_parity;
    logic       bad_stop;
    kind_e      expect_kind;
  } stim_t;

  logic       clk;
  logic       reset;
  logic [1:0] ps2_clk;
  logic [1:0] ps2_data;
  wb_req_t    wb_req;
  wb_rsp_t    wb_rsp;
  logic       irq;

  stim_t      stim [7];
  logic [7:0] codes [DEPTH + 2];
  int         errors;
  int         tests;

  ps2_subsystem #(.QUIET_CYCLES(QUIET)) ps2_subsystem_i (
    .clk(clk), .reset(reset), .ps2_clk(ps2_clk), .ps2_data(ps2_data),
    .wb_req(wb_req), .wb_rsp(wb_rsp), .irq(irq)
  );

  bind ps2_subsystem ps2_assertions ps2_assertions_i (
    .clk(clk), .reset(reset), .wb_rsp(wb_rsp), .wr_en(wr_en), .full(full), .req_ack(ev_ack)
  );

  always #2 clk = ~clk;

  // data changes while the device clock is high.
  task automatic send_frame(input int p, input logic [7:0] code, input logic bad_par,
                            input logic bad_stop, input int nbits);
    logic [10:0] bits;
    bits = {~bad_stop, (~^code) ^ bad_par, code, 1'b0};
    for (int i = 0; i < nbits; i++) begin
      @(negedge clk);
      ps2_data[p] = bits[i];
      repeat (HALF_BIT) @(negedge clk);
      ps2_clk[p] = 1'b0;
      repeat (HALF_BIT) @(negedge clk);
      ps2_clk[p] = 1'b1;
    end
    ps2_data[p] = 1'b1;
    // idle long enough for the quiet timer to close the frame.
    repeat (QUIET + HALF_BIT) @(negedge clk);
  endtask

  task automatic bus_access(input logic we, input logic [1:0] word, input logic [31:0] wdat,
                            output logic [31:0] data);
    int n;
    n = 0;
    @(negedge clk);
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: {word, 2'b00}, dat: wdat};
    while (!wb_rsp.ack && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (!wb_rsp.ack) begin
      $display("wishbone access got no ack within 20 cycles");
      errors++;
    end
    data = wb_rsp.dat;
    wb_req = '0;
  endtask

  task automatic wait_status(input logic [31:0] mask, input logic [31:0] value);
    logic [31:0] st;
    int n;
    n = 0;
    bus_access(1'b0, `PS2_ADDR_STATUS, 32'h0, st);
    while ((st & mask) != value && n < 400) begin
      repeat (4) @(negedge clk);
      bus_access(1'b0, `PS2_ADDR_STATUS, 32'h0, st);
      n++;
    end
    if ((st & mask) != value) begin
      $display("status never reached %h under mask %h, last read %h", value, mask, st);
      errors++;
    end
  endtask

  task automatic expect_data(input logic [31:0] exp, input logic [31:0] mask);
    logic [31:0] got;
    bus_access(1'b0, `PS2_ADDR_DATA, 32'h0, got);
    if ((got & mask) !== (exp & mask)) begin
      $display("ERROR data got %h expected %h", got & mask, exp & mask);
      errors++;
    end
  endtask

  // valid sits in bit 31, parity_err in bit 9 and port in bit 8.
  function automatic logic [31:0] event_word(input logic port, input logic par,
                                             input logic [7:0] code);
    return {1'b1, 21'h0, par, port, code};
  endfunction

  task automatic report_test(input string name, input int base);
    tests++;
    if (errors == base) begin
      $display("test %0d %s passed", tests, name);
    end else begin
      $display("test %0d %s failed with %0d errors", tests, name, errors - base);
    end
  endtask

  initial begin
    int          base;
    logic [31:0] fe;
    logic [31:0] rdat;
    logic [31:0] rd2;
    logic [7:0]  c0;
    logic [7:0]  c1;
    clk = 1'b0;
    reset = 1'b1;
    ps2_clk = 2'b11;
    ps2_data = 2'b11;
    wb_req = '0;
    errors = 0;
    tests = 0;
    void'($urandom(32'h0504_a5be));
    stim[0] = '{1'b0, 8'($urandom), 1'b0, 1'b0, K_GOOD};
    stim[1] = '{1'b1, 8'($urandom), 1'b0, 1'b0, K_GOOD};
    stim[2] = '{1'b0, 8'($urandom), 1'b1, 1'b0, K_PARITY};
    stim[3] = '{1'b1, 8'($urandom), 1'b1, 1'b0, K_PARITY};
    stim[4] = '{1'b0, 8'($urandom), 1'b0, 1'b1, K_STOP};
    stim[5] = '{1'b1, 8'($urandom), 1'b0, 1'b0, K_CUT};
    stim[6] = '{1'b0, 8'($urandom), 1'b0, 1'b0, K_CUT};
    repeat (2) @(negedge clk);
    reset = 1'b0;

    for (int i = 0; i < 7; i++) begin
      base = errors;
      send_frame(stim[i].port, stim[i].code, stim[i].corrupt_parity, stim[i].bad_stop,
                 stim[i].expect_kind == K_CUT ? 6 : 11);
      if (stim[i].expect_kind == K_GOOD || stim[i].expect_kind == K_PARITY) begin
        wait_status(CNT_MASK, 32'h1);
        expect_data(event_word(stim[i].port, stim[i].expect_kind == K_PARITY,
                               stim[i].code), '1);
        expect_data(32'h0, VALID);
      end else begin
        // a dropped frame leaves the fifo empty and only sets its sticky bit.
        fe = 32'h1 << (16 + stim[i].port);
        wait_status(CNT_MASK | fe, fe);
        bus_access(1'b1, `PS2_ADDR_STATUS, fe, rdat);
        bus_access(1'b0, `PS2_ADDR_STATUS, 32'h0, rdat);
        if ((rdat & 32'h000f_001f) !== 32'h0) begin
          $display("ERROR status got %h expected %h", rdat & 32'h000f_001f, 32'h0);
          errors++;
        end
      end
      report_test($sformatf("table entry %0d", i), base);
    end

    base = errors;
    c0 = 8'($urandom);
    c1 = 8'($urandom);
    fork
      send_frame(0, c0, 1'b0, 1'b0, 11);
      send_frame(1, c1, 1'b0, 1'b0, 11);
    join
    wait_status(CNT_MASK, 32'h2);
    bus_access(1'b0, `PS2_ADDR_DATA, 32'h0, rdat);
    bus_access(1'b0, `PS2_ADDR_DATA, 32'h0, rd2);
    if (!((rdat == event_word(0, 0, c0) && rd2 == event_word(1, 0, c1)) ||
          (rdat == event_word(1, 0, c1) && rd2 == event_word(0, 0, c0)))) begin
      $display("ERROR data got %h %h expected %h %h in either order", rdat, rd2,
               event_word(0, 0, c0), event_word(1, 0, c1));
      errors++;
    end
    report_test("both ports at once", base);

    base = errors;
    bus_access(1'b1, `PS2_ADDR_CTRL, 32'h11, rdat);
    c0 = 8'($urandom);
    c1 = 8'($urandom);
    fork
      send_frame(0, c0, 1'b0, 1'b0, 11);
      send_frame(1, c1, 1'b0, 1'b0, 11);
    join
    wait_status(CNT_MASK, 32'h1);
    if (irq !== 1'b1) begin
      $display("ERROR irq got %h expected %h", irq, 1'b1);
      errors++;
    end
    expect_data(event_word(0, 0, c0), '1);
    // irq falls one registered cycle after the pop.
    repeat (2) @(negedge clk);
    if (irq !== 1'b0) begin
      $display("ERROR irq got %h expected %h", irq, 1'b0);
      errors++;
    end
    expect_data(32'h0, VALID);
    bus_access(1'b1, `PS2_ADDR_CTRL, 32'h03, rdat);
    report_test("port disable and irq", base);

    base = errors;
    for (int k = 0; k < DEPTH + 2; k++) begin
      codes[k] = 8'($urandom);
      send_frame(0, codes[k], 1'b0, 1'b0, 11);
      if (k < DEPTH) begin
        wait_status(CNT_MASK, k + 1);
      end
    end
    wait_status(CNT_MASK | 32'h4_0000, 32'h4_0000 | DEPTH);
    // the last frame replaced the one waiting in the receiver.
    for (int k = 0; k <= DEPTH; k++) begin
      expect_data(event_word(0, 0, codes[k == DEPTH ? DEPTH + 1 : k]), '1);
    end
    expect_data(32'h0, VALID);
    report_test("fifo overflow", base);

    $display("tests %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: ps2_subsystem.f
+incdir+include
design/ps2_pkg.sv
design/ps2_receiver.sv
design/ps2_event_arbiter.sv
design/ps2_event_fifo.sv
design/ps2_wb_regs.sv
design/ps2_subsystem.sv
verif/ps2_assertions.sv
verif/ps2_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= ps2_tb
FILELIST   ?= ps2_subsystem.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= Errors found
PASS_MSG   ?= No errors
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation ended before the final report"; exit 1; \
	else \
	  echo "simulation passed"; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
